// ==== verilog.f ====
flash_pkg.sv
flash_serial_engine.sv
flash_bus_port.sv
flash_subsys_top.sv
tb_flash_model.sv
tb_flash_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile with verilator, run, and judge the log

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --top-module tb_flash_top -f verilog.f -o tb_flash_sim \
    || { echo "build failed"; exit 1; }

./obj_dir/tb_flash_sim > sim.log 2>&1 || echo "simulator exited with an error"
cat sim.log

grep -q "TEST RESULT: FAIL" sim.log && { echo "simulation failed"; exit 1; }
grep -q "TEST RESULT: PASS" sim.log || { echo "no result in log"; exit 1; }
exit 0

// ==== tb_flash_top.sv ====
// ******************************
// testbench for the flash read subsystem
// with clock, reset, host reads and checks
// ******************************

`default_nettype none

module tb_flash_top
    import flash_pkg::*;
();

    localparam int timeout = 500;

    logic        clk = 1'b0;
    logic        rst = 1'b1;
    host_req_t   req;
    host_rsp_t   rsp;
    flash_pins_t pins;
    logic [3:0]  din;
    logic        model_err;
    logic [31:0] lfsr = 32'h6b0a7dac;

    always #10 clk = ~clk;

    flash_subsys_top u_flash_subsys_top (
        .clk  (clk),
        .rst  (rst),
        .req  (req),
        .rsp  (rsp),
        .pins (pins),
        .din  (din)
    );

    tb_flash_model u_flash_model (
        .pins      (pins),
        .din       (din),
        .proto_err (model_err)
    );

    // fibonacci lfsr with taps 32 22 2 1
    function automatic logic [31:0] take_bits(int count);
        logic [31:0] value;
        logic        fb;
        value = '0;
        for (int i = 0; i < count; i++) begin
            fb    = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr  = {lfsr[30:0], fb};
            value = {value[30:0], fb};
        end
        return value;
    endfunction

    function automatic flash_addr_t random_addr();
        logic [31:0] r;
        r = take_bits(22);
        return {r[21:0], 2'b00};
    endfunction

    // byte at addr+i lands in bits 8i+7:8i
    function automatic logic [31:0] expected_word(flash_addr_t a);
        logic [31:0] w;
        flash_addr_t b;
        for (int i = 0; i < 4; i++) begin
            b = a + flash_addr_t'(i);
            w[8*i +: 8] = b[7:0] ^ b[15:8] ^ b[23:16] ^ 8'h5A;
        end
        return w;
    endfunction

    task automatic stop_run();
        $display("TEST RESULT: FAIL");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (exp == act) else begin
            $display("MISMATCH %s expected %h actual %h", name, exp, act);
            stop_run();
        end
    endtask

    // one request strobe and a wait for the response at falling edges
    task automatic read_word(input string name, input flash_addr_t a, input logic hold_csn,
                             output int cycles, output logic csn_seen);
        @(negedge clk);
        if (hold_csn) begin
            check_word({name, " csn"}, 32'd0, {31'd0, pins.csn});
        end
        req.strobe = 1'b1;
        req.addr   = a;
        cycles     = 0;
        csn_seen   = 1'b0;
        do begin
            @(negedge clk);
            req.strobe = 1'b0;
            cycles++;
            if (pins.csn) begin
                csn_seen = 1'b1;
            end
            if (hold_csn) begin
                check_word({name, " csn"}, 32'd0, {31'd0, pins.csn});
            end
            if (cycles > timeout) begin
                $display("timeout: no response to %s at address %h", name, a);
                stop_run();
            end
        end while (!rsp.strobe);
        check_word(name, expected_word(a), rsp.data);
    endtask

    task automatic wait_csn_high();
        int cycles;
        cycles = 0;
        while (!pins.csn) begin
            @(negedge clk);
            cycles++;
            if (cycles > timeout) begin
                $display("timeout: chip select never rose after the read");
                stop_run();
            end
        end
    endtask

    always @(negedge clk) begin
        if (model_err) begin
            $display("flash model saw a pin protocol error");
            stop_run();
        end
    end

    initial begin
        flash_addr_t a;
        int          cycles;
        logic        csn_seen;
        req = '0;
        repeat (8) @(negedge clk);
        rst = 1'b0;

        repeat (10) begin
            @(negedge clk);
            check_word("reset csn", 32'd1, {31'd0, pins.csn});
            check_word("reset sclk", 32'd1, {31'd0, pins.sclk});
            check_word("reset oe", 32'd0, {28'd0, pins.oe});
            check_word("reset rsp strobe", 32'd0, {31'd0, rsp.strobe});
        end

        read_word("single read", random_addr(), 1'b0, cycles, csn_seen);

        a = random_addr();
        read_word("stream word 0", a, 1'b0, cycles, csn_seen);
        read_word("stream word 1", a + 24'd4, 1'b1, cycles, csn_seen);
        read_word("stream word 2", a + 24'd8, 1'b1, cycles, csn_seen);

        // let the next word land in the prefetch slot
        a = random_addr();
        read_word("prefetch setup", a, 1'b0, cycles, csn_seen);
        wait_csn_high();
        read_word("prefetch hit", a + 24'd4, 1'b0, cycles, csn_seen);
        check_word("prefetch latency", 32'd1, cycles);

        read_word("restart stream", random_addr(), 1'b0, cycles, csn_seen);
        read_word("restart read", random_addr(), 1'b0, cycles, csn_seen);
        check_word("restart csn high", 32'd1, {31'd0, csn_seen});

        repeat (5) @(negedge clk);
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb_flash_model.sv ====
// ******************************
// behavioral quad-SPI flash for the testbench:
// decodes the fast read quad command and
// returns bytes from a fixed address rule
// ******************************

`default_nettype none

module tb_flash_model
    import flash_pkg::*;
(
    input  flash_pins_t pins,
    output logic [3:0]  din,
    output logic        proto_err
);

    // rising edges before the first data nibble
    localparam int data_edge = 16 + flash_dummy_clocks;

    logic        csn;
    logic        sclk;
    logic [3:0]  nibble = 4'h0;
    logic        err_flag = 1'b0;
    int          txn_id = 0;
    int          seen_txn = 0;
    int          edge_cnt = 0;
    logic [7:0]  cmd_byte;
    logic [7:0]  mode_byte;
    flash_addr_t addr;

    assign csn       = pins.csn;
    assign sclk      = pins.sclk;
    assign din       = nibble;
    assign proto_err = err_flag;

    function automatic logic [7:0] byte_at(flash_addr_t a);
        return a[7:0] ^ a[15:8] ^ a[23:16] ^ 8'h5A;
    endfunction

    // each chip select falling edge opens a new transaction
    always @(negedge csn) begin
        txn_id <= txn_id + 1;
    end

    always @(posedge sclk) begin
        if (!csn) begin
            if (seen_txn != txn_id) begin
                seen_txn = txn_id;
                edge_cnt = 0;
            end
            if (edge_cnt < 8) begin
                cmd_byte = {cmd_byte[6:0], pins.dout[0]};
            end else if (edge_cnt < 14) begin
                addr = {addr[19:0], pins.dout};
            end else if (edge_cnt < 16) begin
                mode_byte = {mode_byte[3:0], pins.dout};
            end else if (edge_cnt >= data_edge) begin
                assert (pins.oe == 4'b0000) else begin
                    $display("controller drives oe=%b while the flash drives din", pins.oe);
                    err_flag = 1'b1;
                end
            end
            edge_cnt = edge_cnt + 1;
            if (edge_cnt == 8) begin
                assert (cmd_byte == flash_read_cmd) else begin
                    $display("MISMATCH command byte expected %h actual %h",
                             flash_read_cmd, cmd_byte);
                    err_flag = 1'b1;
                end
            end
            if (edge_cnt == 16) begin
                assert (mode_byte == flash_mode_byte) else begin
                    $display("MISMATCH mode byte expected %h actual %h",
                             flash_mode_byte, mode_byte);
                    err_flag = 1'b1;
                end
            end
        end
    end

    // high nibble first, address advances every byte
    always @(negedge sclk) begin
        int         n;
        logic [7:0] b;
        if (!csn && seen_txn == txn_id && edge_cnt >= data_edge) begin
            n = edge_cnt - data_edge;
            b = byte_at(addr + flash_addr_t'(n / 2));
            nibble <= n[0] ? b[3:0] : b[7:4];
        end
    end

endmodule

`default_nettype wire

// ==== flash_subsys_top.sv ====
// ******************************
// flash read subsystem: bus port
// joined to the serial engine
// ******************************

`default_nettype none

module flash_subsys_top
    import flash_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  host_req_t   req,
    output host_rsp_t   rsp,
    output flash_pins_t pins,
    input  logic [3:0]  din
);

    logic        rd_valid;
    flash_addr_t rd_addr;
    logic        keep_streaming;
    logic        word_ready;
    logic [31:0] word_data;

    flash_bus_port u_bus_port (
        .clk            (clk),
        .rst            (rst),
        .req            (req),
        .rsp            (rsp),
        .rd_valid       (rd_valid),
        .rd_addr        (rd_addr),
        .keep_streaming (keep_streaming),
        .word_ready     (word_ready),
        .word_data      (word_data)
    );

    flash_serial_engine u_engine (
        .clk            (clk),
        .rst            (rst),
        .rd_valid       (rd_valid),
        .rd_addr        (rd_addr),
        .keep_streaming (keep_streaming),
        .word_ready     (word_ready),
        .word_data      (word_data),
        .pins           (pins),
        .din            (din)
    );

endmodule

`default_nettype wire

// ==== flash_bus_port.sv ====
// ******************************
// host front end: prefetch slot, sequential
// address detection and stream keep/abort
// ******************************

`default_nettype none

module flash_bus_port
    import flash_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  host_req_t   req,
    output host_rsp_t   rsp,
    output logic        rd_valid,
    output flash_addr_t rd_addr,
    output logic        keep_streaming,
    input  logic        word_ready,
    input  logic [31:0] word_data
);

    logic        slot_valid;
    flash_addr_t slot_addr;
    logic [31:0] slot_data;
    flash_addr_t next_addr;
    logic        wait_word;
    logic        restart;
    logic        rsp_strobe;
    logic [31:0] rsp_data;
    logic        word_in;
    logic        slot_hit;
    logic        stream_hit;
    logic        slot_fill;

    // a word seen while rd_valid is low belongs to a stream already dropped
    assign word_in    = word_ready && rd_valid;
    assign slot_hit   = req.strobe && slot_valid && (slot_addr == req.addr);
    assign stream_hit = req.strobe && !slot_hit && rd_valid && (req.addr == next_addr);

    // stream on only while someone wants the word being delivered
    assign keep_streaming = wait_word || stream_hit;
    assign slot_fill      = word_in && !keep_streaming;

    assign rsp.strobe = rsp_strobe;
    assign rsp.data   = rsp_data;

    always_ff @(posedge clk) begin
        if (rst) begin
            rsp_strobe <= 1'b0;
            slot_valid <= 1'b0;
            slot_addr  <= '0;
            next_addr  <= '0;
            wait_word  <= 1'b0;
            restart    <= 1'b0;
            rd_valid   <= 1'b0;
            rd_addr    <= '0;
        end else begin
            rsp_strobe <= 1'b0;

            if (restart) begin
                rd_valid <= 1'b1;
                restart  <= 1'b0;
            end

            if (word_in) begin
                next_addr <= next_addr + 24'd4;
                if (keep_streaming) begin
                    rsp_strobe <= 1'b1;
                    wait_word  <= 1'b0;
                end else begin
                    slot_valid <= 1'b1;
                    slot_addr  <= next_addr;
                    rd_valid   <= 1'b0;
                end
            end

            if (slot_hit) begin
                rsp_strobe <= 1'b1;
                if (!slot_fill) begin
                    slot_valid <= 1'b0;
                end
            end else if (stream_hit) begin
                if (!word_in) begin
                    wait_word <= 1'b1;
                end
            end else if (req.strobe) begin
                // miss, drop rd_valid one cycle and reopen at the new address
                rd_valid  <= 1'b0;
                restart   <= 1'b1;
                rd_addr   <= req.addr;
                next_addr <= req.addr;
                wait_word <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (slot_hit) begin
            rsp_data <= slot_data;
        end else if (word_in) begin
            rsp_data <= word_data;
        end
        if (slot_fill) begin
            slot_data <= word_data;
        end
    end

endmodule

`default_nettype wire

// ==== flash_serial_engine.sv ====
// ******************************
// quad-SPI pin sequencer: command, address, mode,
// dummy clocks, then streamed 32-bit data words
// ******************************

`default_nettype none

module flash_serial_engine
    import flash_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        rd_valid,
    input  flash_addr_t rd_addr,
    input  logic        keep_streaming,
    output logic        word_ready,
    output logic [31:0] word_data,
    output flash_pins_t pins,
    input  logic [3:0]  din
);

    logic [7:0] buffer;
    logic [4:0] xfer_cnt;
    logic [3:0] state;
    logic       cmd_phase;
    logic [1:0] oe_count;
    logic       close;

    // end of transaction: request dropped, or host passed on the next word
    assign close = rst || !rd_valid || (word_ready && !keep_streaming);

    always_ff @(posedge clk) begin
        word_ready <= 1'b0;
        if (close) begin
            pins.csn  <= 1'b1;
            pins.sclk <= 1'b1;
            pins.dout <= 4'b0000;
            pins.oe   <= 4'b0000;
            xfer_cnt  <= 5'd0;
            state     <= 4'd0;
            cmd_phase <= 1'b0;
            oe_count  <= 2'd0;
        end else begin
            pins.csn <= 1'b0;

            if (xfer_cnt != 5'd0) begin
                xfer_cnt <= xfer_cnt - 5'd1;
                if (pins.sclk) begin
                    // falling edge, launch the next bit or nibble
                    pins.sclk <= 1'b0;
                    if (cmd_phase) begin
                        pins.dout <= {3'b000, buffer[7]};
                        pins.oe   <= 4'b0001;
                    end else begin
                        pins.dout <= buffer[7:4];
                        if (oe_count != 2'd0) begin
                            pins.oe  <= 4'b1111;
                            oe_count <= oe_count - 2'd1;
                        end else begin
                            // turnaround, flash owns the bus from here
                            pins.oe <= 4'b0000;
                        end
                    end
                end else begin
                    // rising edge, flash data is stable here
                    pins.sclk <= 1'b1;
                    if (cmd_phase) begin
                        buffer <= {buffer[6:0], 1'b0};
                    end else begin
                        buffer <= {buffer[3:0], din};
                    end
                end
            end else begin
                case (state)
                    4'd0: begin
                        buffer    <= flash_read_cmd;
                        xfer_cnt  <= flash_cmd_half_clocks;
                        cmd_phase <= 1'b1;
                        state     <= 4'd1;
                    end
                    4'd1: begin
                        buffer    <= rd_addr[23:16];
                        xfer_cnt  <= flash_quad_half_clocks;
                        cmd_phase <= 1'b0;
                        oe_count  <= flash_quad_oe_clocks;
                        state     <= 4'd2;
                    end
                    4'd2: begin
                        buffer   <= rd_addr[15:8];
                        xfer_cnt <= flash_quad_half_clocks;
                        oe_count <= flash_quad_oe_clocks;
                        state    <= 4'd3;
                    end
                    4'd3: begin
                        buffer   <= rd_addr[7:0];
                        xfer_cnt <= flash_quad_half_clocks;
                        oe_count <= flash_quad_oe_clocks;
                        state    <= 4'd4;
                    end
                    4'd4: begin
                        // mode nibbles driven, dummy clocks run with oe low
                        buffer   <= flash_mode_byte;
                        xfer_cnt <= flash_mode_half_clocks;
                        oe_count <= flash_quad_oe_clocks;
                        state    <= 4'd5;
                    end
                    4'd5: begin
                        // first data byte, nothing to store yet
                        xfer_cnt <= flash_quad_half_clocks;
                        oe_count <= 2'd0;
                        state    <= 4'd6;
                    end
                    4'd6: begin
                        word_data[7:0] <= buffer;
                        xfer_cnt       <= flash_quad_half_clocks;
                        state          <= 4'd7;
                    end
                    4'd7: begin
                        word_data[15:8] <= buffer;
                        xfer_cnt        <= flash_quad_half_clocks;
                        state           <= 4'd8;
                    end
                    4'd8: begin
                        word_data[23:16] <= buffer;
                        xfer_cnt         <= flash_quad_half_clocks;
                        state            <= 4'd9;
                    end
                    default: begin
                        // word complete, already clocking the next one
                        word_data[31:24] <= buffer;
                        word_ready       <= 1'b1;
                        xfer_cnt         <= flash_quad_half_clocks;
                        state            <= 4'd6;
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// ==== flash_pkg.sv ====
// ******************************
// shared definitions for the quad-SPI flash read path:
// protocol constants, transfer lengths and the
// host request/response and flash pin structs
// ******************************

`default_nettype none

package flash_pkg;

    // fast read quad i/o, command on one line
    localparam logic [7:0] flash_read_cmd = 8'hEB;

    // mode bits sent after the address, no continuous read
    localparam logic [7:0] flash_mode_byte = 8'h00;

    localparam int flash_dummy_clocks = 4;

    // transfer lengths in half SPI clocks
    localparam logic [4:0] flash_cmd_half_clocks  = 5'd16;
    localparam logic [4:0] flash_quad_half_clocks = 5'd4;
    localparam logic [4:0] flash_mode_half_clocks = 5'(2 * (2 + flash_dummy_clocks));

    // falling edges with the quad bus driven for address and mode
    localparam logic [1:0] flash_quad_oe_clocks = 2'd2;

    typedef logic [23:0] flash_addr_t;

    typedef struct packed {
        logic        strobe;
        flash_addr_t addr;
    } host_req_t;

    typedef struct packed {
        logic        strobe;
        logic [31:0] data;
    } host_rsp_t;

    // controller side of the flash pins
    typedef struct packed {
        logic       csn;
        logic       sclk;
        logic [3:0] dout;
        logic [3:0] oe;
    } flash_pins_t;

endpackage

`default_nettype wire
